/* hdl/debayer_pkg.sv */
//**************************************************************************
// Debayer package
// Pixel widths, line addressing, buffer depth and the RGB pixel type
//**************************************************************************

package debayer_pkg;

    // Raw sample width, also the width of each colour channel
    localparam int PIXEL_BITS = 10;

    // Column address, enough for lines of 2048 pixels
    localparam int LINE_ADDR_BITS = 11;

    // Line buffers keep the upper bits only
    localparam int STORED_BITS = 9;     // LSB dropped

    // Entries in the elastic buffer between debayer and packer
    localparam int FIFO_DEPTH = 64;

    // One interpolated pixel, 31 bits packed
    typedef struct packed {
        logic [PIXEL_BITS-1:0] red;
        logic [PIXEL_BITS-1:0] green;
        logic [PIXEL_BITS-1:0] blue;
        logic                  last;    // Final output pixel of a line
    } rgb_pixel_t;

endpackage

/* hdl/debayer_line_buffer.sv */
//**************************************************************************
// Debayer line buffer
// One raw line of storage with a registered three-tap window on the read side
//**************************************************************************

module debayer_line_buffer (
    input  logic                                    clock_in,
    input  logic                                    reset_n_in,

    // Write port, one raw pixel per cycle
    input  logic                                    write_enable,
    input  logic [debayer_pkg::LINE_ADDR_BITS-1:0]  write_address,
    input  logic [debayer_pkg::PIXEL_BITS-1:0]      write_data,

    // Read port, window of the last three words read
    input  logic [debayer_pkg::LINE_ADDR_BITS-1:0]  read_address,
    output logic [2:0][debayer_pkg::PIXEL_BITS-1:0] read_window
);

    import debayer_pkg::*;

    localparam int LINE_WORDS = 1 << LINE_ADDR_BITS;

    logic [STORED_BITS-1:0] mem [LINE_WORDS];   // 2048 x 9 bits

    // Read history, newest word enters at tap_new
    logic [STORED_BITS-1:0] tap_old;
    logic [STORED_BITS-1:0] tap_mid;
    logic [STORED_BITS-1:0] tap_new;

    always_ff @(posedge clock_in) begin
        if (write_enable) begin
            mem[write_address] <= write_data[PIXEL_BITS-1:PIXEL_BITS-STORED_BITS];
        end
    end

    // One read per cycle, shifted through the history
    always_ff @(posedge clock_in) begin
        tap_new <= mem[read_address];
        tap_mid <= tap_new;
        tap_old <= tap_mid;
    end

    // Back to full width with a zero LSB
    assign read_window[0] = {tap_old, 1'b0};   // Leftmost column
    assign read_window[1] = {tap_mid, 1'b0};
    assign read_window[2] = {tap_new, 1'b0};   // Rightmost column

    // Writer must trail the reader, never collide with it
    a_no_collision : assert property (
        @(posedge clock_in) disable iff (!reset_n_in)
        write_enable |-> write_address != read_address
    );

endmodule

/* hdl/debayer.sv */
//**************************************************************************
// Debayer
// Bilinear interpolation of a BGGR raw stream into one RGB pixel per site
//**************************************************************************

module debayer (
    input  logic                               clock_in,
    input  logic                               reset_n_in,

    // Raw sensor stream, cannot stall
    input  logic [debayer_pkg::PIXEL_BITS-1:0] raw_data,
    input  logic                               line_valid,
    input  logic                               frame_valid,

    // Interpolated pixels, one-cycle pulse each
    output logic                               out_valid,
    output debayer_pkg::rgb_pixel_t            out_data
);

    import debayer_pkg::*;

    logic                      accept;          // Pixel taken this cycle
    logic                      line_valid_d;
    logic                      line_end;
    logic [LINE_ADDR_BITS-1:0] col_count;       // Column of the incoming pixel
    logic [LINE_ADDR_BITS-1:0] row_count;       // Row of the incoming pixel
    logic [LINE_ADDR_BITS-1:0] last_col;        // Last column of the previous row
    logic [LINE_ADDR_BITS-1:0] read_address;

    // Two-stage delay of the current row, also the line buffer write pipe
    logic                      valid_d1;
    logic                      valid_d2;
    logic                      odd_d1;
    logic                      odd_d2;
    logic [LINE_ADDR_BITS-1:0] col_d1;
    logic [LINE_ADDR_BITS-1:0] col_d2;
    logic [PIXEL_BITS-1:0]     pixel_d1;
    logic [PIXEL_BITS-1:0]     pixel_d2;

    logic                      write_enable_a;
    logic                      write_enable_b;
    logic [2:0][PIXEL_BITS-1:0] window_a;
    logic [2:0][PIXEL_BITS-1:0] window_b;
    logic [2:0][PIXEL_BITS-1:0] top;            // Row r-1
    logic [2:0][PIXEL_BITS-1:0] mid;            // Row r
    logic [2:0][PIXEL_BITS-1:0] bot;            // Row r+1, full precision

    logic                      site_row_odd;
    logic                      site_col_odd;
    rgb_pixel_t                pixel_next;

    function automatic logic [PIXEL_BITS-1:0] avg2(
        input logic [PIXEL_BITS-1:0] a,
        input logic [PIXEL_BITS-1:0] b
    );
        logic [PIXEL_BITS:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        return sum[PIXEL_BITS:1];               // Truncating
    endfunction

    function automatic logic [PIXEL_BITS-1:0] avg4(
        input logic [PIXEL_BITS-1:0] a,
        input logic [PIXEL_BITS-1:0] b,
        input logic [PIXEL_BITS-1:0] c,
        input logic [PIXEL_BITS-1:0] d
    );
        logic [PIXEL_BITS+1:0] sum;
        sum = {2'b00, a} + {2'b00, b} + {2'b00, c} + {2'b00, d};
        return sum[PIXEL_BITS+1:2];
    endfunction

    assign accept   = frame_valid && line_valid;
    assign line_end = line_valid_d && !line_valid;

    // Fetch next column so the window is aligned when it arrives
    assign read_address = accept ? col_count + 1'b1 : '0;

    // Row parity picks the buffer, written two columns late
    assign write_enable_a = valid_d2 && !odd_d2;
    assign write_enable_b = valid_d2 && odd_d2;

    debayer_line_buffer i_line_buffer_a (
        .clock_in      (clock_in),
        .reset_n_in    (reset_n_in),
        .write_enable  (write_enable_a),
        .write_address (col_d2),
        .write_data    (pixel_d2),
        .read_address  (read_address),
        .read_window   (window_a)
    );

    debayer_line_buffer i_line_buffer_b (
        .clock_in      (clock_in),
        .reset_n_in    (reset_n_in),
        .write_enable  (write_enable_b),
        .write_address (col_d2),
        .write_data    (pixel_d2),
        .read_address  (read_address),
        .read_window   (window_b)
    );

    // Row y-2 sits in buffer[y%2], row y-1 in the other one
    assign top = row_count[0] ? window_b : window_a;
    assign mid = row_count[0] ? window_a : window_b;
    assign bot = {raw_data, pixel_d1, pixel_d2};

    // Site is one row up and one column left
    assign site_row_odd = !row_count[0];
    assign site_col_odd = !col_count[0];

    always_comb begin
        pixel_next = '0;
        unique case ({site_row_odd, site_col_odd})
            2'b00: begin                                        // B site
                pixel_next.blue  = mid[1];
                pixel_next.green = avg4(top[1], mid[0], mid[2], bot[1]);
                pixel_next.red   = avg4(top[0], top[2], bot[0], bot[2]);
            end
            2'b01: begin                                        // Gb site
                pixel_next.green = mid[1];
                pixel_next.blue  = avg2(mid[0], mid[2]);        // B left and right
                pixel_next.red   = avg2(top[1], bot[1]);        // R above and below
            end
            2'b10: begin                                        // Gr site
                pixel_next.green = mid[1];
                pixel_next.red   = avg2(mid[0], mid[2]);
                pixel_next.blue  = avg2(top[1], bot[1]);
            end
            default: begin                                      // R site
                pixel_next.red   = mid[1];
                pixel_next.green = avg4(top[1], mid[0], mid[2], bot[1]);
                pixel_next.blue  = avg4(top[0], top[2], bot[0], bot[2]);
            end
        endcase
        pixel_next.last = (col_count == last_col);              // Site column W-2
    end

    // Counters and outputs, cleared between frames
    always_ff @(posedge clock_in) begin
        if (!reset_n_in || !frame_valid) begin
            col_count    <= '0;
            row_count    <= '0;
            line_valid_d <= 1'b0;
            out_valid    <= 1'b0;
            out_data     <= '0;
        end else begin
            line_valid_d <= line_valid;
            if (accept) begin
                col_count <= col_count + 1'b1;
            end else begin
                col_count <= '0;
            end
            if (line_end) begin
                row_count <= row_count + 1'b1;
            end
            // Interior sites only, needs two rows and two columns behind
            out_valid <= accept && (col_count >= 2) && (row_count >= 2);
            if (accept) begin
                out_data <= pixel_next;
            end
        end
    end

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            valid_d1 <= 1'b0;
            valid_d2 <= 1'b0;
        end else begin
            valid_d1 <= accept;
            valid_d2 <= valid_d1;   // Runs on in blanking to flush the row tail
        end
    end

    always_ff @(posedge clock_in) begin
        pixel_d1 <= raw_data;
        pixel_d2 <= pixel_d1;
        col_d1   <= col_count;
        col_d2   <= col_d1;
        odd_d1   <= row_count[0];
        odd_d2   <= odd_d1;
        if (line_end) begin
            last_col <= col_count - 1'b1;   // Width of the row just ended
        end
    end

    // No output pulse outside a frame
    a_out_in_frame : assert property (
        @(posedge clock_in) disable iff (!reset_n_in)
        !frame_valid |-> !out_valid
    );

    // Line ends before the column counter runs out
    a_col_no_wrap : assert property (
        @(posedge clock_in) disable iff (!reset_n_in)
        (accept && col_count == '1) |=> !accept
    );

endmodule

/* hdl/pixel_fifo.sv */
//**************************************************************************
// Pixel FIFO
// Synchronous buffer with valid/ready on both sides and a sticky overflow
//**************************************************************************

module pixel_fifo #(
    parameter type T     = debayer_pkg::rgb_pixel_t,
    parameter int  DEPTH = debayer_pkg::FIFO_DEPTH
) (
    input  logic clock_in,
    input  logic reset_n_in,

    input  logic in_valid,
    input  T     in_data,
    output logic in_ready,

    output logic out_valid,
    output T     out_data,
    input  logic out_ready,

    output logic overflow       // Sticky until reset
);

    localparam int PTR_BITS   = $clog2(DEPTH);
    localparam int COUNT_BITS = $clog2(DEPTH + 1);

    T                     mem [DEPTH];
    logic [PTR_BITS-1:0]  wr_ptr;
    logic [PTR_BITS-1:0]  rd_ptr;
    logic [COUNT_BITS-1:0] count;           // Occupancy
    logic                 push;
    logic                 pop;

    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
        return (ptr == PTR_BITS'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign in_ready  = (count != COUNT_BITS'(DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];         // Read from storage, no bypass
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (push) wr_ptr <= next_ptr(wr_ptr);
            if (pop)  rd_ptr <= next_ptr(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (in_valid && !in_ready) begin
                overflow <= 1'b1;           // Write dropped
            end
        end
    end

    always_ff @(posedge clock_in) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    a_count_bound : assert property (
        @(posedge clock_in) disable iff (!reset_n_in)
        count <= COUNT_BITS'(DEPTH)
    );

    // Held output stays put until taken
    a_out_stable : assert property (
        @(posedge clock_in) disable iff (!reset_n_in)
        (out_valid && !out_ready) |=> out_valid && $stable(out_data)
    );

endmodule

/* hdl/rgb565_packer.sv */
//**************************************************************************
// RGB565 packer
// Rounds and saturates 10-bit RGB into 16-bit words on a valid/ready port
//**************************************************************************

module rgb565_packer (
    input  logic                    clock_in,
    input  logic                    reset_n_in,

    input  logic                    in_valid,
    input  debayer_pkg::rgb_pixel_t in_data,
    output logic                    in_ready,

    output logic                    rgb565_valid,
    output logic [15:0]             rgb565_data,
    output logic                    rgb565_last,
    input  logic                    rgb565_ready
);

    import debayer_pkg::*;

    logic       accept;
    logic [5:0] red_round;
    logic [5:0] green_round;
    logic [5:0] blue_round;

    // Round to nearest by half an output step, then clip
    function automatic logic [5:0] round_sat(
        input logic [PIXEL_BITS-1:0] value,
        input int                    shift
    );
        logic [PIXEL_BITS:0] sum;
        logic [PIXEL_BITS:0] scaled;
        logic [PIXEL_BITS:0] limit;
        sum    = {1'b0, value} + ((PIXEL_BITS + 1)'(1) << (shift - 1));
        scaled = sum >> shift;
        limit  = ((PIXEL_BITS + 1)'(1) << (PIXEL_BITS - shift)) - 1'b1;
        if (scaled > limit) begin
            scaled = limit;
        end
        return scaled[5:0];
    endfunction

    assign red_round   = round_sat(in_data.red, 5);     // 5 bits
    assign green_round = round_sat(in_data.green, 4);   // 6 bits
    assign blue_round  = round_sat(in_data.blue, 5);

    // Take a pixel when empty or when the held word leaves
    assign in_ready = !rgb565_valid || rgb565_ready;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            rgb565_valid <= 1'b0;
        end else if (in_ready) begin
            rgb565_valid <= in_valid;
        end
    end

    always_ff @(posedge clock_in) begin
        if (accept) begin
            rgb565_data <= {red_round[4:0], green_round, blue_round[4:0]};
            rgb565_last <= in_data.last;
        end
    end

    a_hold_word : assert property (
        @(posedge clock_in) disable iff (!reset_n_in)
        (rgb565_valid && !rgb565_ready) |=>
            rgb565_valid && $stable(rgb565_data) && $stable(rgb565_last)
    );

endmodule

/* hdl/debayer_top.sv */
//**************************************************************************
// Debayer top
// Raw Bayer stream in, RGB565 words out through an elastic buffer
//**************************************************************************

module debayer_top (
    input  logic                               clock_in,
    input  logic                               reset_n_in,

    // Sensor side
    input  logic [debayer_pkg::PIXEL_BITS-1:0] raw_data,
    input  logic                               line_valid,
    input  logic                               frame_valid,

    // Packed output
    output logic                               rgb565_valid,
    output logic [15:0]                        rgb565_data,
    output logic                               rgb565_last,
    input  logic                               rgb565_ready,

    output logic                               overflow
);

    import debayer_pkg::*;

    logic       debayer_valid;
    rgb_pixel_t debayer_data;
    logic       fifo_valid;
    rgb_pixel_t fifo_data;
    logic       fifo_ready;

    debayer i_debayer (
        .clock_in    (clock_in),
        .reset_n_in  (reset_n_in),
        .raw_data    (raw_data),
        .line_valid  (line_valid),
        .frame_valid (frame_valid),
        .out_valid   (debayer_valid),
        .out_data    (debayer_data)
    );

    // Sensor cannot stall, so in_ready only feeds the overflow flag
    pixel_fifo #(
        .T     (rgb_pixel_t),
        .DEPTH (FIFO_DEPTH)
    ) i_pixel_fifo (
        .clock_in   (clock_in),
        .reset_n_in (reset_n_in),
        .in_valid   (debayer_valid),
        .in_data    (debayer_data),
        .in_ready   (),
        .out_valid  (fifo_valid),
        .out_data   (fifo_data),
        .out_ready  (fifo_ready),
        .overflow   (overflow)
    );

    rgb565_packer i_rgb565_packer (
        .clock_in     (clock_in),
        .reset_n_in   (reset_n_in),
        .in_valid     (fifo_valid),
        .in_data      (fifo_data),
        .in_ready     (fifo_ready),
        .rgb565_valid (rgb565_valid),
        .rgb565_data  (rgb565_data),
        .rgb565_last  (rgb565_last),
        .rgb565_ready (rgb565_ready)
    );

endmodule

/* dv/debayer_tb.sv */
//**************************************************************************
// Debayer testbench
// LFSR raw frames through the pipeline, checked against a bilinear model
//**************************************************************************

module debayer_tb;

    timeunit 1ns;
    timeprecision 100ps;

    logic        clock_in;
    logic        reset_n_in;
    logic [9:0]  raw_data;
    logic        line_valid;
    logic        frame_valid;
    logic        rgb565_valid;
    logic [15:0] rgb565_data;
    logic        rgb565_last;
    logic        rgb565_ready;
    logic        overflow;

    logic [9:0]  frame_pix [8][16];         // Raw frame being sent
    int          frame_width;
    int          frame_height;
    logic [16:0] expected_q [$];            // {last, word}
    logic [31:0] lfsr_state = 32'h6cfa;
    int          ready_mode;                // 0 high, 1 random, 2 held low

    debayer_top i_dut (.*);

    initial begin
        clock_in = 1'b0;
        forever #2 clock_in = ~clock_in;    // 4 ns period
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // Rows r-1 and r come back from line storage without their LSB
    function automatic int sample(input int row, input int col, input int site_row);
        logic [9:0] value;
        value = frame_pix[row][col];
        if (row <= site_row) value[0] = 1'b0;
        return int'(value);
    endfunction

    // Round half up, clip at full scale, pack as R5 G6 B5
    function automatic logic [15:0] pack565(input int red, input int green, input int blue);
        int r5;
        int g6;
        int b5;
        r5 = (red + 16) >> 5;
        g6 = (green + 8) >> 4;
        b5 = (blue + 16) >> 5;
        return {(r5 > 31) ? 5'd31 : r5[4:0], (g6 > 63) ? 6'd63 : g6[5:0],
                (b5 > 31) ? 5'd31 : b5[4:0]};
    endfunction

    // Bilinear BGGR reference, one queue entry per interior site
    function automatic void model_frame();
        int          own;
        int          horiz;
        int          vert;
        int          orth;
        int          diag;
        logic [15:0] word;
        for (int r = 1; r < frame_height - 1; r++) begin
            for (int c = 1; c < frame_width - 1; c++) begin
                own   = sample(r, c, r);
                horiz = (sample(r, c - 1, r) + sample(r, c + 1, r)) >> 1;
                vert  = (sample(r - 1, c, r) + sample(r + 1, c, r)) >> 1;
                orth  = (sample(r, c - 1, r) + sample(r, c + 1, r)
                       + sample(r - 1, c, r) + sample(r + 1, c, r)) >> 2;
                diag  = (sample(r - 1, c - 1, r) + sample(r - 1, c + 1, r)
                       + sample(r + 1, c - 1, r) + sample(r + 1, c + 1, r)) >> 2;
                case (2 * (r % 2) + c % 2)
                    0: word = pack565(diag, orth, own);         // B site
                    1: word = pack565(vert, own, horiz);        // Gb, R above and below
                    2: word = pack565(horiz, own, vert);        // Gr
                    default: word = pack565(own, orth, diag);   // R site
                endcase
                expected_q.push_back({c == frame_width - 2, word});
            end
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR: %s is 0x%0h, expected 0x%0h", name, actual, expected);
            $display("RESULT: FAIL");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1, "%s", reason);
    endtask

    // Next edge plus 1 ns, then output ready for this cycle
    task automatic drive_cycle();
        logic [31:0] bits;
        @(posedge clock_in);
        #1;
        bits = (ready_mode == 1) ? take_bits(2) : 32'h1;
        rgb565_ready = (ready_mode != 2) && (bits[1:0] != 2'b00);   // 3 of 4 when random
    endtask

    // Negative level asks for LFSR pixels
    function automatic void fill_frame(input int width, input int height, input int level);
        frame_width  = width;
        frame_height = height;
        for (int r = 0; r < height; r++) begin
            for (int c = 0; c < width; c++) begin
                frame_pix[r][c] = (level < 0) ? 10'(take_bits(10)) : 10'(level);
            end
        end
        model_frame();
    endfunction

    // Every model word of a flat frame is one constant
    task automatic check_flat(input logic [15:0] word);
        foreach (expected_q[i]) begin
            check_value("flat model word", 32'(expected_q[i][15:0]), 32'(word));
        end
    endtask

    // Row by row, blanking after each line
    task automatic stream_frame(input int line_gap);
        frame_valid = 1'b1;
        for (int r = 0; r < frame_height; r++) begin
            for (int c = 0; c < frame_width; c++) begin
                line_valid = 1'b1;
                raw_data   = frame_pix[r][c];
                drive_cycle();
            end
            line_valid = 1'b0;
            raw_data   = '0;
            repeat (line_gap) drive_cycle();
        end
        frame_valid = 1'b0;                 // Counters clear between frames
        repeat (4) drive_cycle();
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (expected_q.size() != 0) begin
            if (cycles == 4000) begin
                stop_run("Timeout, expected words still pending after 4000 cycles");
            end
            drive_cycle();
            cycles++;
        end
    endtask

    // Handshake sampled mid-cycle, where valid and ready are settled
    initial begin
        logic [16:0] entry;
        forever begin
            @(negedge clock_in);
            if (reset_n_in && rgb565_valid && rgb565_ready) begin
                if (expected_q.size() == 0) begin
                    stop_run("Output word arrived with no expected word pending");
                end else begin
                    entry = expected_q.pop_front();
                    check_value("rgb565_data", 32'(rgb565_data), 32'(entry[15:0]));
                    check_value("rgb565_last", 32'(rgb565_last), 32'(entry[16]));
                end
            end
        end
    end

    initial begin
        reset_n_in   = 1'b0;
        raw_data     = '0;
        line_valid   = 1'b0;
        frame_valid  = 1'b0;
        rgb565_ready = 1'b1;
        ready_mode   = 0;
        repeat (4) @(posedge clock_in);     // Reset held 4 cycles
        #1;
        reset_n_in = 1'b1;
        drive_cycle();
        check_value("rgb565_valid", 32'(rgb565_valid), 32'h0);
        check_value("overflow", 32'(overflow), 32'h0);

        fill_frame(12, 6, 'h155);           // Flat level, every site gives one word
        check_flat(16'h5aab);
        stream_frame(4);
        wait_drain();

        fill_frame(16, 8, -1);              // 6 rows of 14 sites
        check_value("expected word count", 32'(expected_q.size()), 32'd84);
        stream_frame(4);
        wait_drain();

        ready_mode = 1;                     // Same frame, throttled output
        model_frame();
        stream_frame(32);
        wait_drain();
        ready_mode = 0;
        check_value("overflow", 32'(overflow), 32'h0);

        fill_frame(16, 8, -1);              // Back to back, two widths
        stream_frame(4);
        fill_frame(10, 8, -1);
        stream_frame(4);
        wait_drain();

        fill_frame(8, 4, 'h3ff);            // Full scale saturates all channels
        check_flat(16'hffff);
        stream_frame(4);
        wait_drain();
        check_value("overflow", 32'(overflow), 32'h0);

        fill_frame(16, 8, -1);              // 84 sites against a stalled output
        ready_mode = 2;
        stream_frame(4);
        check_value("overflow", 32'(overflow), 32'h1);
        while (expected_q.size() > 65) begin
            void'(expected_q.pop_back());   // Packer word plus 64 FIFO entries survive
        end
        ready_mode = 0;
        wait_drain();

        repeat (20) drive_cycle();          // Stray words show up here
        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* verilog.f */
hdl/debayer_pkg.sv
hdl/debayer_line_buffer.sv
hdl/debayer.sv
hdl/pixel_fifo.sv
hdl/rgb565_packer.sv
hdl/debayer_top.sv
dv/debayer_tb.sv

/* Makefile */
TOP := debayer_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f verilog.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "RESULT: FAIL" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
